// File: include/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// cache geometry
`define ICACHE_WAYS         4
`define ICACHE_SETS         64

// fetch and memory widths
`define ICACHE_ADDR_W       32
`define ICACHE_WORD_W       32

// refill line length in words, one memory beat per word
`define ICACHE_LINE_WORDS   4

// victim lfsr start value, must not be zero
`define ICACHE_LFSR_SEED    8'h5a

`endif

// File: verilog/icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

    typedef logic [`ICACHE_WORD_W-1:0]                      word_t;
    typedef logic [`ICACHE_LINE_WORDS*`ICACHE_WORD_W-1:0]   line_t;
    typedef logic [`ICACHE_ADDR_W-1:0]                      byte_addr_t;
    typedef logic [`ICACHE_ADDR_W-$clog2(`ICACHE_WORD_W/8)-1:0] word_addr_t;

    // word address splits into tag, index, offset (msb first)
    typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0]          offset_t;
    typedef logic [$clog2(`ICACHE_SETS)-1:0]                index_t;
    typedef logic [$bits(word_addr_t)-$bits(index_t)-$bits(offset_t)-1:0] tag_t;

    typedef logic [$clog2(`ICACHE_WAYS)-1:0]                way_t;
    typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0]          beat_t;

    typedef enum logic [2:0] {
        RESP_OKAY   = 3'd0,
        RESP_SLVERR = 3'd2
    } resp_e;

    typedef enum logic [2:0] {
        IDLE        = 3'b000,
        REFILL_ADDR = 3'b011,
        REFILL_DATA = 3'b111,
        FILL        = 3'b001,
        RESPOND     = 3'b010
    } cache_state_e;

endpackage

// File: verilog/tag_array.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module tag_array (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    lookup_en,
    input  icache_pkg::word_addr_t  ifu_raddr,
    input  logic                    fill_we,
    input  icache_pkg::tag_t        req_tag,
    input  icache_pkg::index_t      req_index,
    output logic                    hit,
    output icache_pkg::way_t        hit_way,
    output icache_pkg::way_t        fill_way
);

    icache_pkg::tag_t           lookup_tag;
    icache_pkg::index_t         lookup_index;
    icache_pkg::tag_t           tag_q [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]    valid_q [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0]    match;
    icache_pkg::way_t           match_way;
    logic [7:0]                 lfsr_q;

    assign lookup_tag   = ifu_raddr[$bits(icache_pkg::word_addr_t)-1 -: $bits(icache_pkg::tag_t)];
    assign lookup_index = ifu_raddr[$bits(icache_pkg::offset_t) +: $bits(icache_pkg::index_t)];

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        logic way_we;

        assign way_we = fill_we && (fill_way == icache_pkg::way_t'(w));

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                valid_q[w] <= '0;
            end else if (way_we) begin
                valid_q[w][req_index] <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (way_we) begin
                tag_q[w][req_index] <= req_tag;
            end
        end

        assign match[w] = valid_q[w][lookup_index] && (tag_q[w][lookup_index] == lookup_tag);
    end

    // at most one way matches, fills only happen on a miss
    always_comb begin
        match_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (match[w]) begin
                match_way = icache_pkg::way_t'(w);
            end
        end
    end

    assign hit = |match;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_way <= '0;
        end else if (lookup_en) begin
            hit_way <= match_way;
        end
    end

    // x^8 + x^6 + x^5 + x^4 + 1, free running
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= `ICACHE_LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    assign fill_way = lfsr_q[$bits(icache_pkg::way_t)-1:0];

endmodule

// File: verilog/data_array.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module data_array (
    input  logic                    clk,
    input  logic                    lookup_en,
    input  icache_pkg::word_addr_t  ifu_raddr,
    input  icache_pkg::way_t        hit_way,
    input  logic                    fill_we,
    input  icache_pkg::way_t        fill_way,
    input  icache_pkg::index_t      req_index,
    input  icache_pkg::line_t       fill_line,
    output icache_pkg::line_t       array_line
);

    icache_pkg::index_t lookup_index;
    icache_pkg::line_t  rd_q [`ICACHE_WAYS];

    assign lookup_index = ifu_raddr[$bits(icache_pkg::offset_t) +: $bits(icache_pkg::index_t)];

    // one sram-style line memory per way, all read in parallel
    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_pkg::line_t mem [`ICACHE_SETS];

        always_ff @(posedge clk) begin
            if (fill_we && (fill_way == icache_pkg::way_t'(w))) begin
                mem[req_index] <= fill_line;
            end
        end

        // read data held until the next lookup
        always_ff @(posedge clk) begin
            if (lookup_en) begin
                rd_q[w] <= mem[lookup_index];
            end
        end
    end

    // hit_way registers on the same edge as the read
    assign array_line = rd_q[hit_way];

endmodule

// File: verilog/line_buffer.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module line_buffer (
    input  logic                    clk,
    input  logic                    beat_en,
    input  icache_pkg::word_t       mem_rdata,
    input  logic                    use_buffer,
    input  icache_pkg::line_t       array_line,
    input  icache_pkg::offset_t     req_offset,
    output icache_pkg::line_t       fill_line,
    output icache_pkg::word_t       ifu_rdata
);

    icache_pkg::line_t  line_q;
    icache_pkg::line_t  sel_line;

    // beats enter at the top and move down, beat 0 lands in word 0
    always_ff @(posedge clk) begin
        if (beat_en) begin
            line_q <= {mem_rdata, line_q[$bits(icache_pkg::line_t)-1:`ICACHE_WORD_W]};
        end
    end

    assign fill_line = line_q;

    // refill answers from the buffer, hits from the array
    assign sel_line  = use_buffer ? line_q : array_line;

    assign ifu_rdata = sel_line[req_offset * `ICACHE_WORD_W +: `ICACHE_WORD_W];

endmodule

// File: verilog/refill_tracker.sv
`timescale 1ns/10ps

module refill_tracker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    lookup_en,
    input  icache_pkg::word_addr_t  ifu_raddr,
    input  logic                    beat_en,
    input  icache_pkg::resp_e       mem_rresp,
    output icache_pkg::tag_t        req_tag,
    output icache_pkg::index_t      req_index,
    output icache_pkg::offset_t     req_offset,
    output icache_pkg::byte_addr_t  mem_araddr,
    output logic                    last_beat,
    output logic                    refill_error
);

    icache_pkg::beat_t  beat_q;
    logic               error_q;

    // request fields, held for the whole transaction
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            {req_tag, req_index, req_offset} <= ifu_raddr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q  <= '0;
            error_q <= 1'b0;
        end else if (lookup_en) begin
            beat_q  <= '0;
            error_q <= 1'b0;
        end else if (beat_en) begin
            beat_q  <= beat_q + 1'b1;
            error_q <= refill_error;
        end
    end

    // includes the beat arriving now, so the fsm sees an error on the last beat
    assign refill_error = error_q || (beat_en && (mem_rresp != icache_pkg::RESP_OKAY));
    assign last_beat    = (beat_q == '1);

    // line base plus beat number, word aligned
    assign mem_araddr   = {req_tag, req_index, beat_q, 2'b00};

endmodule

// File: verilog/icache_ctrl_fsm.sv
`timescale 1ns/10ps

module icache_ctrl_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ifu_arvalid,
    output logic                ifu_arready,
    output logic                ifu_rvalid,
    input  logic                ifu_rready,
    output icache_pkg::resp_e   ifu_rresp,
    output logic                mem_arvalid,
    input  logic                mem_arready,
    input  logic                mem_rvalid,
    input  logic                hit,
    input  logic                last_beat,
    input  logic                refill_error,
    output logic                lookup_en,
    output logic                beat_en,
    output logic                fill_we,
    output logic                use_buffer
);

    icache_pkg::cache_state_e   state_q;
    icache_pkg::cache_state_e   state_d;
    icache_pkg::resp_e          resp_q;
    logic                       use_buffer_q;

    // one request in flight, so new requests only in idle
    assign ifu_arready = (state_q == icache_pkg::IDLE);
    assign lookup_en   = ifu_arvalid && ifu_arready;

    assign mem_arvalid = (state_q == icache_pkg::REFILL_ADDR);
    // single outstanding beat, accepted whenever it shows up
    assign beat_en     = (state_q == icache_pkg::REFILL_DATA) && mem_rvalid;
    assign fill_we     = (state_q == icache_pkg::FILL);

    assign ifu_rvalid  = (state_q == icache_pkg::RESPOND);
    assign ifu_rresp   = resp_q;
    assign use_buffer  = use_buffer_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE: begin
                if (lookup_en) begin
                    if (hit) begin
                        state_d = icache_pkg::RESPOND;
                    end else begin
                        state_d = icache_pkg::REFILL_ADDR;
                    end
                end
            end
            icache_pkg::REFILL_ADDR: begin
                if (mem_arready) begin
                    state_d = icache_pkg::REFILL_DATA;
                end
            end
            icache_pkg::REFILL_DATA: begin
                if (beat_en) begin
                    if (!last_beat) begin
                        state_d = icache_pkg::REFILL_ADDR;
                    end else if (refill_error) begin
                        // bad line is dropped, no fill
                        state_d = icache_pkg::RESPOND;
                    end else begin
                        state_d = icache_pkg::FILL;
                    end
                end
            end
            icache_pkg::FILL: begin
                state_d = icache_pkg::RESPOND;
            end
            icache_pkg::RESPOND: begin
                if (ifu_rready) begin
                    state_d = icache_pkg::IDLE;
                end
            end
            default: begin
                state_d = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= icache_pkg::IDLE;
            resp_q       <= icache_pkg::RESP_OKAY;
            use_buffer_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (lookup_en) begin
                resp_q       <= icache_pkg::RESP_OKAY;
                // misses answer from the refill buffer
                use_buffer_q <= !hit;
            end else if (beat_en && last_beat) begin
                if (refill_error) begin
                    resp_q <= icache_pkg::RESP_SLVERR;
                end else begin
                    resp_q <= icache_pkg::RESP_OKAY;
                end
            end
        end
    end

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/10ps

module icache_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ifu_arvalid,
    output logic                    ifu_arready,
    input  icache_pkg::word_addr_t  ifu_raddr,
    output logic                    ifu_rvalid,
    input  logic                    ifu_rready,
    output icache_pkg::word_t       ifu_rdata,
    output icache_pkg::resp_e       ifu_rresp,
    output logic                    mem_arvalid,
    input  logic                    mem_arready,
    output icache_pkg::byte_addr_t  mem_araddr,
    input  logic                    mem_rvalid,
    input  icache_pkg::resp_e       mem_rresp,
    input  icache_pkg::word_t       mem_rdata
);

    // fsm strobes
    logic                   lookup_en;
    logic                   beat_en;
    logic                   fill_we;
    logic                   use_buffer;

    // tracker state
    icache_pkg::tag_t       req_tag;
    icache_pkg::index_t     req_index;
    icache_pkg::offset_t    req_offset;
    logic                   last_beat;
    logic                   refill_error;

    // lookup results
    logic                   hit;
    icache_pkg::way_t       hit_way;
    icache_pkg::way_t       fill_way;

    icache_pkg::line_t      fill_line;
    icache_pkg::line_t      array_line;

    icache_ctrl_fsm u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .ifu_arvalid  (ifu_arvalid),
        .ifu_arready  (ifu_arready),
        .ifu_rvalid   (ifu_rvalid),
        .ifu_rready   (ifu_rready),
        .ifu_rresp    (ifu_rresp),
        .mem_arvalid  (mem_arvalid),
        .mem_arready  (mem_arready),
        .mem_rvalid   (mem_rvalid),
        .hit          (hit),
        .last_beat    (last_beat),
        .refill_error (refill_error),
        .lookup_en    (lookup_en),
        .beat_en      (beat_en),
        .fill_we      (fill_we),
        .use_buffer   (use_buffer)
    );

    refill_tracker u_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_en    (lookup_en),
        .ifu_raddr    (ifu_raddr),
        .beat_en      (beat_en),
        .mem_rresp    (mem_rresp),
        .req_tag      (req_tag),
        .req_index    (req_index),
        .req_offset   (req_offset),
        .mem_araddr   (mem_araddr),
        .last_beat    (last_beat),
        .refill_error (refill_error)
    );

    tag_array u_tags (
        .clk       (clk),
        .rst_n     (rst_n),
        .lookup_en (lookup_en),
        .ifu_raddr (ifu_raddr),
        .fill_we   (fill_we),
        .req_tag   (req_tag),
        .req_index (req_index),
        .hit       (hit),
        .hit_way   (hit_way),
        .fill_way  (fill_way)
    );

    data_array u_data (
        .clk        (clk),
        .lookup_en  (lookup_en),
        .ifu_raddr  (ifu_raddr),
        .hit_way    (hit_way),
        .fill_we    (fill_we),
        .fill_way   (fill_way),
        .req_index  (req_index),
        .fill_line  (fill_line),
        .array_line (array_line)
    );

    line_buffer u_linebuf (
        .clk        (clk),
        .beat_en    (beat_en),
        .mem_rdata  (mem_rdata),
        .use_buffer (use_buffer),
        .array_line (array_line),
        .req_offset (req_offset),
        .fill_line  (fill_line),
        .ifu_rdata  (ifu_rdata)
    );

endmodule

// File: tb/icache_properties.sv
`timescale 1ns/10ps

module icache_properties (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     ifu_arready,
    input logic                     ifu_rvalid,
    input logic                     ifu_rready,
    input icache_pkg::word_t        ifu_rdata,
    input icache_pkg::resp_e        ifu_rresp,
    input logic                     mem_arvalid,
    input logic                     mem_arready,
    input icache_pkg::byte_addr_t   mem_araddr
);

    int unsigned fail_count = 0;

    // response payload held while the fetch unit stalls
    ifu_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (ifu_rvalid && !ifu_rready) |=> (ifu_rvalid && $stable(ifu_rdata) && $stable(ifu_rresp)))
    else begin
        fail_count++;
        $error("ifu response dropped or changed before ifu_rready");
    end

    mem_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_arvalid && !mem_arready) |=> (mem_arvalid && $stable(mem_araddr)))
    else begin
        fail_count++;
        $error("memory request dropped or changed before mem_arready");
    end

    // response handshake returns the cache to idle
    idle_after_resp: assert property (@(posedge clk) disable iff (!rst_n)
        (ifu_rvalid && ifu_rready) |=> ifu_arready)
    else begin
        fail_count++;
        $error("ifu_arready low in the cycle after the response handshake");
    end

endmodule

// File: tb/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;

    localparam int unsigned WAIT_LIMIT  = 200;
    // word address bit 25 sits in the tag
    localparam int          ERR_TAG_BIT = 25 - $bits(icache_pkg::index_t)
                                             - $bits(icache_pkg::offset_t);

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   ifu_arvalid;
    logic                   ifu_arready;
    icache_pkg::word_addr_t ifu_raddr;
    logic                   ifu_rvalid;
    logic                   ifu_rready;
    icache_pkg::word_t      ifu_rdata;
    icache_pkg::resp_e      ifu_rresp;
    logic                   mem_arvalid;
    logic                   mem_arready;
    icache_pkg::byte_addr_t mem_araddr;
    logic                   mem_rvalid;
    icache_pkg::resp_e      mem_rresp;
    icache_pkg::word_t      mem_rdata;

    icache_pkg::byte_addr_t reads_seen [$];
    int unsigned            error_count;
    int unsigned            check_count;
    int unsigned            test_count;
    int unsigned            failed_tests;
    bit                     aborted;

    icache_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ifu_arvalid (ifu_arvalid),
        .ifu_arready (ifu_arready),
        .ifu_raddr   (ifu_raddr),
        .ifu_rvalid  (ifu_rvalid),
        .ifu_rready  (ifu_rready),
        .ifu_rdata   (ifu_rdata),
        .ifu_rresp   (ifu_rresp),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_araddr  (mem_araddr),
        .mem_rvalid  (mem_rvalid),
        .mem_rresp   (mem_rresp),
        .mem_rdata   (mem_rdata)
    );

    bind icache_top icache_properties props_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ifu_arready (ifu_arready),
        .ifu_rvalid  (ifu_rvalid),
        .ifu_rready  (ifu_rready),
        .ifu_rdata   (ifu_rdata),
        .ifu_rresp   (ifu_rresp),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_araddr  (mem_araddr)
    );

    always #5 clk = ~clk;

    // memory contents as a fixed mix of address bits
    function automatic icache_pkg::word_t ref_word(icache_pkg::byte_addr_t addr);
        return {addr[15:0], addr[31:16]} ^ (addr << 3) ^ 32'h5bd1_e995;
    endfunction

    function automatic bit error_region(icache_pkg::byte_addr_t addr);
        return addr[27];
    endfunction

    function automatic icache_pkg::resp_e ref_resp(icache_pkg::word_addr_t addr);
        return error_region({addr, 2'b00}) ? icache_pkg::RESP_SLVERR : icache_pkg::RESP_OKAY;
    endfunction

    function automatic icache_pkg::word_addr_t make_addr(icache_pkg::tag_t tag,
            icache_pkg::index_t index, icache_pkg::offset_t offset);
        return {tag, index, offset};
    endfunction

    task automatic record_error();
        error_count++;
    endtask

    task automatic check_word(string what, icache_pkg::word_t got, icache_pkg::word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            record_error();
        end
    endtask

    task automatic check_resp(string what, icache_pkg::resp_e got, icache_pkg::resp_e exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
            record_error();
        end
    endtask

    task automatic check_addr(string what, icache_pkg::byte_addr_t got,
            icache_pkg::byte_addr_t exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            record_error();
        end
    endtask

    task automatic check_read_count(string what, int unsigned exp);
        check_count++;
        if (reads_seen.size() != exp) begin
            $display("ERROR at %0t: %s issued %0d memory reads, expected %0d",
                     $time, what, reads_seen.size(), exp);
            record_error();
        end
    endtask

    task automatic report_test(string name, int unsigned errs_before);
        test_count++;
        if (aborted) begin
            failed_tests++;
            $display("test %s: not completed", name);
        end else if (error_count != errs_before) begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, error_count - errs_before);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    // one full request that starts and ends 1 ns after a rising edge
    task automatic fetch(input icache_pkg::word_addr_t addr, input int unsigned max_gap,
            output icache_pkg::word_t data, output icache_pkg::resp_e resp,
            output int unsigned latency);
        int unsigned cycles;
        int unsigned gap;
        bit          seen;
        reads_seen.delete();
        data    = '0;
        resp    = icache_pkg::RESP_OKAY;
        latency = 0;
        if (aborted) return;
        ifu_raddr   = addr;
        ifu_arvalid = 1'b1;
        cycles      = 0;
        seen        = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            seen = ifu_arready;
            @(posedge clk);
            #1;
            cycles++;
        end
        ifu_arvalid = 1'b0;
        if (!seen) begin
            $display("request %h was not accepted within %0d cycles", addr, WAIT_LIMIT);
            record_error();
            aborted = 1'b1;
            return;
        end
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            seen = ifu_rvalid;
            if (!seen && ifu_arready) begin
                $display("ERROR at %0t: ifu_arready rose before the response to %h",
                         $time, addr);
                record_error();
            end
            if (!seen) begin
                @(posedge clk);
                #1;
            end
        end
        if (!seen) begin
            $display("no response to request %h within %0d cycles", addr, WAIT_LIMIT);
            record_error();
            aborted = 1'b1;
            return;
        end
        latency = cycles;
        data    = ifu_rdata;
        resp    = ifu_rresp;
        gap     = (max_gap == 0) ? 0 : $urandom_range(max_gap, 0);
        for (int i = 0; i < gap; i++) begin
            @(posedge clk);
            #1;
            @(negedge clk);
            if (!ifu_rvalid || ifu_arready) begin
                $display("ERROR at %0t: response to %h withdrawn without ifu_rready",
                         $time, addr);
                record_error();
            end
            check_word("held ifu_rdata", ifu_rdata, data);
            check_resp("held ifu_rresp", ifu_rresp, resp);
        end
        @(posedge clk);
        #1 ifu_rready = 1'b1;
        @(posedge clk);
        #1 ifu_rready = 1'b0;
        @(negedge clk);
        if (!ifu_arready) begin
            $display("ERROR at %0t: cache not idle after the response handshake", $time);
            record_error();
        end
        @(posedge clk);
        #1;
    endtask

    task automatic miss_test(icache_pkg::word_addr_t addr, string name);
        int unsigned            errs_before;
        icache_pkg::word_t      data;
        icache_pkg::resp_e      resp;
        int unsigned            lat;
        icache_pkg::byte_addr_t base;
        errs_before = error_count;
        base        = {addr[$bits(addr)-1:2], 4'b0000};
        fetch(addr, 0, data, resp, lat);
        if (!aborted) begin
            check_word("miss data", data, ref_word({addr, 2'b00}));
            check_resp("miss resp", resp, icache_pkg::RESP_OKAY);
            check_read_count("miss", 4);
            for (int k = 0; k < reads_seen.size() && k < 4; k++) begin
                check_addr($sformatf("refill read %0d", k), reads_seen[k],
                           base + icache_pkg::byte_addr_t'(4 * k));
            end
        end
        report_test(name, errs_before);
    endtask

    task automatic hit_test(icache_pkg::word_addr_t line_addr);
        int unsigned            errs_before;
        icache_pkg::word_addr_t addr;
        icache_pkg::word_t      data;
        icache_pkg::resp_e      resp;
        int unsigned            lat;
        errs_before = error_count;
        for (int o = 3; o >= 0; o--) begin
            addr = {line_addr[$bits(addr)-1:2], icache_pkg::offset_t'(o)};
            fetch(addr, 0, data, resp, lat);
            check_word($sformatf("hit word %0d", o), data, ref_word({addr, 2'b00}));
            check_read_count("hit", 0);
            if (!aborted && lat != 1) begin
                $display("ERROR at %0t: hit latency is %0d cycles, expected 1", $time, lat);
                record_error();
            end
        end
        report_test("hit after fill", errs_before);
    endtask

    task automatic error_test(icache_pkg::word_addr_t addr);
        int unsigned       errs_before;
        icache_pkg::word_t data;
        icache_pkg::resp_e resp;
        int unsigned       lat;
        errs_before = error_count;
        for (int n = 0; n < 2; n++) begin
            fetch(addr, 0, data, resp, lat);
            check_resp("error region resp", resp, icache_pkg::RESP_SLVERR);
            check_read_count("error region request", 4);
        end
        report_test("error region", errs_before);
    endtask

    // mixed hits and misses with addr_count requests over tag_count tags
    task automatic stream_test(string name, int unsigned addr_count, int unsigned tag_count,
            int unsigned max_gap);
        int unsigned            errs_before;
        icache_pkg::tag_t       tags [8];
        icache_pkg::index_t     sets [3];
        icache_pkg::word_addr_t addr;
        icache_pkg::word_t      data;
        icache_pkg::resp_e      resp;
        int unsigned            lat;
        errs_before = error_count;
        for (int i = 0; i < 8; i++) begin
            tags[i]              = icache_pkg::tag_t'($urandom);
            tags[i][ERR_TAG_BIT] = 1'b0;
        end
        for (int i = 0; i < 3; i++) begin
            sets[i] = icache_pkg::index_t'($urandom);
        end
        for (int n = 0; n < addr_count && !aborted; n++) begin
            addr = make_addr(tags[$urandom_range(tag_count - 1, 0)], sets[$urandom_range(2, 0)],
                             icache_pkg::offset_t'($urandom));
            fetch(addr, max_gap, data, resp, lat);
            check_word($sformatf("stream word %h", addr), data, ref_word({addr, 2'b00}));
            check_resp($sformatf("stream resp %h", addr), resp, ref_resp(addr));
        end
        report_test(name, errs_before);
    endtask

    // memory model with one beat outstanding and random accept and data delays
    initial begin : memory_model
        icache_pkg::byte_addr_t addr;
        int unsigned            gap;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        mem_rresp   = icache_pkg::RESP_OKAY;
        forever begin
            @(negedge clk);
            if (rst_n && mem_arvalid) begin
                addr = mem_araddr;
                gap  = $urandom_range(3, 0);
                for (int i = 0; i <= gap; i++) begin
                    @(posedge clk);
                    #1;
                end
                mem_arready = 1'b1;
                @(posedge clk);
                reads_seen.push_back(addr);
                #1 mem_arready = 1'b0;
                gap = $urandom_range(3, 0);
                for (int i = 0; i < gap; i++) begin
                    @(posedge clk);
                    #1;
                end
                mem_rvalid = 1'b1;
                mem_rdata  = ref_word(addr);
                mem_rresp  = error_region(addr) ? icache_pkg::RESP_SLVERR : icache_pkg::RESP_OKAY;
                @(posedge clk);
                #1 mem_rvalid = 1'b0;
            end
        end
    end

    initial begin : main
        icache_pkg::word_addr_t addr;
        void'($urandom(61622));
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        aborted      = 1'b0;
        rst_n        = 1'b0;
        ifu_arvalid  = 1'b0;
        ifu_raddr    = '0;
        ifu_rready   = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        if (!ifu_arready || ifu_rvalid || mem_arvalid) begin
            $display("ERROR at %0t: handshake outputs wrong after reset", $time);
            record_error();
        end
        @(posedge clk);
        #1;
        addr              = icache_pkg::word_addr_t'($urandom);
        addr[25]          = 1'b0;
        miss_test(addr, "cold miss");
        addr              = icache_pkg::word_addr_t'($urandom);
        addr[25]          = 1'b0;
        miss_test(addr, "refill reads");
        hit_test(addr);
        addr              = icache_pkg::word_addr_t'($urandom);
        addr[25]          = 1'b1;
        error_test(addr);
        stream_test("back-pressure", 12, 2, 6);
        stream_test("random stream", 300, 6, 2);
        error_count = error_count + dut_i.props_i.fail_count;
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+include
verilog/icache_pkg.sv
verilog/tag_array.sv
verilog/data_array.sv
verilog/line_buffer.sv
verilog/refill_tracker.sv
verilog/icache_ctrl_fsm.sv
verilog/icache_top.sv
tb/icache_properties.sv
tb/icache_tb.sv

// File: run.sh
#!/bin/sh
# build the icache testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module icache_tb -f src.f -o icache_sim \
    || { echo "verilator build failed"; exit 1; }

# raise the error limit so assertion failures reach the testbench report
./obj_dir/icache_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
